// File: mmu.f
source/mmu_pkg.sv
source/tlb_entry_array.sv
source/tlb_translate.sv
source/tlb_maint.sv
source/mmu_top.sv
verif/mmu_tb.sv

// File: Bender.yml
package:
  name: mmu

sources:
  - source/mmu_pkg.sv
  - source/tlb_entry_array.sv
  - source/tlb_translate.sv
  - source/tlb_maint.sv
  - source/mmu_top.sv
  - target: simulation
    files:
      - verif/mmu_tb.sv

// File: verif/mmu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_tb import mmu_pkg::*; ;

    logic clk, rst_n, inst_req, data_req, data_wr;
    logic [31:0] inst_vaddr, data_vaddr, entryhi, entrylo0, entrylo1, index;
    logic [7:0] asid, cur_asid;
    tlb_op_e op;
    logic inst_done, inst_cached, data_done, data_cached, op_done;
    logic [31:0] inst_paddr, data_paddr, read_entryhi, read_entrylo0, read_entrylo1, probe_index;
    tlb_exc_e inst_exc, data_exc;
    logic [31:0] lfsr_state;
    // model copies of what was written, in register format
    logic [31:0] tb_hi [TLB_ENTRIES];
    logic [31:0] tb_lo0 [TLB_ENTRIES];
    logic [31:0] tb_lo1 [TLB_ENTRIES];

    mmu_top mmu_top_i (.*);

    always #50 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run("value mismatch");
        end
    endtask

    task automatic check_exc(input string name, input tlb_exc_e got, input tlb_exc_e exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
            abort_run("exception code mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
            abort_run("flag mismatch");
        end
    endtask

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
        end
        return r;
    endfunction

    function automatic logic [31:0] make_lo(input logic [19:0] pfn, input logic [2:0] c,
                                            input logic d, input logic v, input logic g);
        return {6'b0, pfn, c, d, v, g};
    endfunction

    task automatic do_op(input tlb_op_e o, input logic [31:0] hi, input logic [31:0] lo0,
                         input logic [31:0] lo1, input int idx);
        int n;
        @(negedge clk);
        op = o;
        entryhi = hi;
        entrylo0 = lo0;
        entrylo1 = lo1;
        index = idx;
        @(negedge clk);
        op = op_none;
        n = 0;
        while (!op_done && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (!op_done) abort_run("timed out waiting for op_done");
    endtask

    task automatic write_entry(input int idx, input logic [18:0] vpn2, input logic [7:0] as,
                               input logic [31:0] lo0, input logic [31:0] lo1);
        tb_hi[idx] = {vpn2, 5'b0, as};
        tb_lo0[idx] = lo0;
        tb_lo1[idx] = lo1;
        // junk in the unused fields must be dropped
        do_op(op_tlbwi, {vpn2, 5'h1f, as}, lo0 | 32'hfc00_0000, lo1 | 32'hfc00_0000, idx);
    endtask

    task automatic wait_done(input logic on_data, output int cycles);
        logic dn;
        cycles = 0;
        dn = 1'b0;
        while (!dn && cycles < 20) begin
            @(negedge clk);
            cycles++;
            dn = on_data ? data_done : inst_done;
        end
        if (!dn) abort_run("timed out waiting for translation done");
    endtask

    task automatic expect_result(input logic on_data, input tlb_exc_e exp_exc,
                                 input logic [31:0] exp_pa, input logic exp_c);
        if (on_data) begin
            check_exc("data_exc", data_exc, exp_exc);
            if (exp_exc == exc_none) begin
                check_word("data_paddr", data_paddr, exp_pa);
                check_bit("data_cached", data_cached, exp_c);
            end
        end else begin
            check_exc("inst_exc", inst_exc, exp_exc);
            if (exp_exc == exc_none) begin
                check_word("inst_paddr", inst_paddr, exp_pa);
                check_bit("inst_cached", inst_cached, exp_c);
            end
        end
    endtask

    task automatic translate(input logic on_data, input logic st, input logic [31:0] va,
                             input tlb_exc_e exp_exc, input logic [31:0] exp_pa, input logic exp_c);
        int n;
        @(negedge clk);
        if (on_data) begin
            data_req = 1'b1;
            data_wr = st;
            data_vaddr = va;
        end else begin
            inst_req = 1'b1;
            inst_vaddr = va;
        end
        wait_done(on_data, n);
        data_req = 1'b0;
        inst_req = 1'b0;
        data_wr = 1'b0;
        if (n != 1) abort_run("translation done did not follow the request by one cycle");
        expect_result(on_data, exp_exc, exp_pa, exp_c);
    endtask

    task automatic unmapped_segments();
        logic [31:0] va [4];
        logic [31:0] pa [4];
        logic        exp_c [4];
        // kseg0 drops 0x8 from the top nibble, kseg1 drops 0xa
        va = '{32'h8123_4567, 32'h9abc_def0, 32'ha000_1234, 32'hbfff_fff0};
        pa = '{32'h0123_4567, 32'h1abc_def0, 32'h0000_1234, 32'h1fff_fff0};
        exp_c = '{1'b1, 1'b1, 1'b0, 1'b0};
        for (int i = 0; i < 4; i++) begin
            translate(1'b1, 1'b0, va[i], exc_none, pa[i], exp_c[i]);
            translate(1'b1, 1'b1, va[i], exc_none, pa[i], exp_c[i]);
            translate(1'b0, 1'b0, va[i], exc_none, pa[i], exp_c[i]);
        end
    endtask

    task automatic write_then_translate();
        logic [2:0] c;
        logic [11:0] off;
        cur_asid = 8'(rand_bits(8));
        asid = cur_asid;
        for (int i = 0; i < 4; i++) begin
            c = (i == 0) ? CACHE_CACHED : ((i == 1) ? 3'd2 : 3'(rand_bits(3)));
            write_entry(i, {1'b0, 18'(rand_bits(18))}, cur_asid,
                        make_lo(20'(rand_bits(20)), c, 1, 1, 0),
                        make_lo(20'(rand_bits(20)), 3'(rand_bits(3)), 1, 1, 0));
        end
        for (int i = 0; i < 4; i++) begin
            off = 12'(rand_bits(12));
            translate(1'b1, 1'b0, {tb_hi[i][31:13], 1'b0, off}, exc_none,
                      {tb_lo0[i][25:6], off}, tb_lo0[i][5:3] == CACHE_CACHED);
            translate(1'b0, 1'b0, {tb_hi[i][31:13], 1'b1, off}, exc_none,
                      {tb_lo1[i][25:6], off}, tb_lo1[i][5:3] == CACHE_CACHED);
            translate(1'b1, 1'b1, {tb_hi[i][31:13], 1'b1, off}, exc_none,
                      {tb_lo1[i][25:6], off}, tb_lo1[i][5:3] == CACHE_CACHED);
        end
    endtask

    task automatic exception_codes();
        logic [31:0] absent;
        absent = {19'h7ffff, 1'b0, 12'h010};
        translate(1'b1, 1'b0, absent, exc_refill_load, 0, 0);
        translate(1'b1, 1'b1, absent, exc_refill_store, 0, 0);
        translate(1'b0, 1'b0, absent, exc_refill_load, 0, 0);
        // even page invalid, odd page clean
        write_entry(4, {1'b0, 18'(rand_bits(18))}, cur_asid,
                    make_lo(20'(rand_bits(20)), 3, 1, 0, 0),
                    make_lo(20'(rand_bits(20)), 3, 0, 1, 0));
        translate(1'b1, 1'b0, {tb_hi[4][31:13], 13'h0044}, exc_invalid_load, 0, 0);
        translate(1'b1, 1'b1, {tb_hi[4][31:13], 13'h0044}, exc_invalid_store, 0, 0);
        translate(1'b1, 1'b1, {tb_hi[4][31:13], 13'h1044}, exc_modified, 0, 0);
        translate(1'b1, 1'b0, {tb_hi[4][31:13], 13'h1044}, exc_none,
                  {tb_lo1[4][25:6], 12'h044}, 1'b1);
        asid = cur_asid ^ 8'h5a;
        translate(1'b1, 1'b0, {tb_hi[0][31:13], 13'h0100}, exc_refill_load, 0, 0);
        write_entry(5, {1'b0, 18'(rand_bits(18))}, cur_asid,
                    make_lo(20'(rand_bits(20)), 2, 1, 1, 1),
                    make_lo(20'(rand_bits(20)), 2, 1, 1, 1));
        translate(1'b1, 1'b0, {tb_hi[5][31:13], 13'h0100}, exc_none,
                  {tb_lo0[5][25:6], 12'h100}, 1'b0);
        write_entry(6, {1'b0, 18'(rand_bits(18))}, cur_asid,
                    make_lo(20'(rand_bits(20)), 3, 1, 1, 1),
                    make_lo(20'(rand_bits(20)), 3, 1, 1, 0));
        translate(1'b1, 1'b0, {tb_hi[6][31:13], 13'h0100}, exc_refill_load, 0, 0);
        asid = cur_asid;
    endtask

    task automatic read_back();
        logic g;
        for (int idx = 5; idx < 7; idx++) begin
            do_op(op_tlbr, 0, 0, 0, idx);
            g = tb_lo0[idx][0] & tb_lo1[idx][0];
            check_word("read_entryhi", read_entryhi, tb_hi[idx]);
            check_word("read_entrylo0", read_entrylo0, {tb_lo0[idx][31:1], g});
            check_word("read_entrylo1", read_entrylo1, {tb_lo1[idx][31:1], g});
        end
    endtask

    task automatic stalled_request();
        int n;
        @(negedge clk);
        data_req = 1'b1;
        data_vaddr = {tb_hi[1][31:13], 13'h0abc};
        op = op_tlbp;
        entryhi = tb_hi[3];
        @(negedge clk);
        check_bit("data_done", data_done, 1'b0);
        check_bit("op_done", op_done, 1'b1);
        op = op_none;
        wait_done(1'b1, n);
        data_req = 1'b0;
        expect_result(1'b1, exc_none, {tb_lo0[1][25:6], 12'habc}, 1'b0);
        check_word("probe_index", probe_index, 32'd3);
    endtask

    task automatic probe_and_random();
        logic [18:0] vpn2;
        logic [31:0] lo0;
        do_op(op_tlbp, tb_hi[2], 0, 0, 0);
        check_word("probe_index", probe_index, 32'd2);
        do_op(op_tlbp, {19'h7ffff, 5'b0, cur_asid}, 0, 0, 0);
        check_word("probe_index", probe_index, 32'h8000_0000);
        vpn2 = {1'b0, 18'(rand_bits(18))};
        lo0 = make_lo(20'(rand_bits(20)), 3, 1, 1, 0);
        do_op(op_tlbwr, {vpn2, 5'b0, cur_asid}, lo0,
              make_lo(20'(rand_bits(20)), 3, 1, 1, 0), 0);
        do_op(op_tlbp, {vpn2, 5'b0, cur_asid}, 0, 0, 0);
        check_bit("probe_index[31]", probe_index[31], 1'b0);
        if (probe_index >= TLB_ENTRIES) abort_run("TLBWR wrote outside the TLB");
        translate(1'b1, 1'b0, {vpn2, 13'h0321}, exc_none, {lo0[25:6], 12'h321}, 1'b1);
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        inst_req = 1'b0;
        inst_vaddr = '0;
        data_req = 1'b0;
        data_wr = 1'b0;
        data_vaddr = '0;
        asid = '0;
        op = op_none;
        entryhi = '0;
        entrylo0 = '0;
        entrylo1 = '0;
        index = '0;
        lfsr_state = 32'h3b5f;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_bit("data_done", data_done, 1'b0);
        check_bit("op_done", op_done, 1'b0);
        check_exc("inst_exc", inst_exc, exc_none);
        check_word("probe_index", probe_index, 32'd0);
        unmapped_segments();
        write_then_translate();
        exception_codes();
        read_back();
        stalled_request();
        probe_and_random();
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// File: source/mmu_top.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_top import mmu_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        inst_req,
    input  wire logic [31:0] inst_vaddr,
    input  wire logic        data_req,
    input  wire logic        data_wr,
    input  wire logic [31:0] data_vaddr,
    input  wire logic [7:0]  asid,
    input  wire tlb_op_e     op,
    input  wire logic [31:0] entryhi,
    input  wire logic [31:0] entrylo0,
    input  wire logic [31:0] entrylo1,
    input  wire logic [31:0] index,
    output logic             inst_done,
    output logic      [31:0] inst_paddr,
    output logic             inst_cached,
    output tlb_exc_e         inst_exc,
    output logic             data_done,
    output logic      [31:0] data_paddr,
    output logic             data_cached,
    output tlb_exc_e         data_exc,
    output logic             op_done,
    output logic      [31:0] read_entryhi,
    output logic      [31:0] read_entrylo0,
    output logic      [31:0] read_entrylo1,
    output logic      [31:0] probe_index
);

    logic [TLB_ENTRIES*19-1:0] ent_vpn2;
    logic [TLB_ENTRIES*8-1:0]  ent_asid;
    logic [TLB_ENTRIES-1:0]    ent_g;
    logic [TLB_ENTRIES*25-1:0] ent_lo0;
    logic [TLB_ENTRIES*25-1:0] ent_lo1;

    logic                 stall;
    logic                 probe;
    logic [18:0]          probe_vpn2;
    logic                 hit;
    logic [TLB_IDX_W-1:0] hit_index;
    logic                 wr_en;
    logic [TLB_IDX_W-1:0] wr_index;
    logic [31:0]          wr_entryhi;
    logic [31:0]          wr_entrylo0;
    logic [31:0]          wr_entrylo1;
    logic [TLB_IDX_W-1:0] rd_index;
    logic [31:0]          rd_entryhi;
    logic [31:0]          rd_entrylo0;
    logic [31:0]          rd_entrylo1;
    logic [7:0]           data_asid;

    // TLBP compares against the ASID held in EntryHi
    assign data_asid = probe ? entryhi[7:0] : asid;

    tlb_entry_array entry_array (
        .clk, .rst_n, .wr_en, .wr_index, .wr_entryhi, .wr_entrylo0, .wr_entrylo1,
        .rd_index, .rd_entryhi, .rd_entrylo0, .rd_entrylo1,
        .ent_vpn2, .ent_asid, .ent_g, .ent_lo0, .ent_lo1
    );

    tlb_maint maint (
        .clk, .rst_n, .op, .entryhi, .entrylo0, .entrylo1, .index, .hit, .hit_index,
        .rd_entryhi, .rd_entrylo0, .rd_entrylo1, .op_done, .stall, .probe, .probe_vpn2,
        .wr_en, .wr_index, .wr_entryhi, .wr_entrylo0, .wr_entrylo1, .rd_index,
        .read_entryhi, .read_entrylo0, .read_entrylo1, .probe_index
    );

    // fetch never stores and never probes
    tlb_translate inst_port (
        .clk, .rst_n, .req(inst_req), .wr(1'b0), .vaddr(inst_vaddr), .asid, .stall,
        .probe(1'b0), .probe_vpn2(19'd0), .ent_vpn2, .ent_asid, .ent_g, .ent_lo0, .ent_lo1,
        .done(inst_done), .paddr(inst_paddr), .cached(inst_cached), .exc(inst_exc),
        .hit(), .hit_index()
    );

    tlb_translate data_port (
        .clk, .rst_n, .req(data_req), .wr(data_wr), .vaddr(data_vaddr), .asid(data_asid),
        .stall, .probe, .probe_vpn2, .ent_vpn2, .ent_asid, .ent_g, .ent_lo0, .ent_lo1,
        .done(data_done), .paddr(data_paddr), .cached(data_cached), .exc(data_exc),
        .hit, .hit_index
    );

endmodule

`default_nettype wire

// File: source/tlb_maint.sv
`timescale 1ns/1ps
`default_nettype none

module tlb_maint import mmu_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire tlb_op_e               op,
    input  wire logic [31:0]           entryhi,
    input  wire logic [31:0]           entrylo0,
    input  wire logic [31:0]           entrylo1,
    input  wire logic [31:0]           index,
    input  wire logic                  hit,
    input  wire logic [TLB_IDX_W-1:0]  hit_index,
    input  wire logic [31:0]           rd_entryhi,
    input  wire logic [31:0]           rd_entrylo0,
    input  wire logic [31:0]           rd_entrylo1,
    output logic                       op_done,
    output logic                       stall,
    output logic                       probe,
    output logic      [18:0]           probe_vpn2,
    output logic                       wr_en,
    output logic      [TLB_IDX_W-1:0]  wr_index,
    output logic      [31:0]           wr_entryhi,
    output logic      [31:0]           wr_entrylo0,
    output logic      [31:0]           wr_entrylo1,
    output logic      [TLB_IDX_W-1:0]  rd_index,
    output logic      [31:0]           read_entryhi,
    output logic      [31:0]           read_entrylo0,
    output logic      [31:0]           read_entrylo1,
    output logic      [31:0]           probe_index
);

    logic [TLB_IDX_W-1:0] random_q;

    assign stall      = (op != op_none);
    assign probe      = (op == op_tlbp);
    assign probe_vpn2 = entryhi[31:13];
    assign rd_index   = index[TLB_IDX_W-1:0];

    assign wr_en       = (op == op_tlbwi) || (op == op_tlbwr);
    assign wr_index    = (op == op_tlbwr) ? random_q : index[TLB_IDX_W-1:0];
    // asid field and vpn2 only, pagemask is fixed at zero
    assign wr_entryhi  = {entryhi[31:13], 5'b0, entryhi[7:0]};
    assign wr_entrylo0 = {6'b0, entrylo0[25:0]};
    assign wr_entrylo1 = {6'b0, entrylo1[25:0]};

    // free-running, counts down
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            random_q <= TLB_IDX_W'(TLB_ENTRIES - 1);
        end else if (random_q == '0) begin
            random_q <= TLB_IDX_W'(TLB_ENTRIES - 1);
        end else begin
            random_q <= random_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            op_done       <= 1'b0;
            read_entryhi  <= '0;
            read_entrylo0 <= '0;
            read_entrylo1 <= '0;
            probe_index   <= '0;
        end else begin
            op_done <= (op != op_none);
            if (op == op_tlbr) begin
                read_entryhi  <= {rd_entryhi[31:13], 5'b0, rd_entryhi[7:0]};
                read_entrylo0 <= {6'b0, rd_entrylo0[25:0]};
                read_entrylo1 <= {6'b0, rd_entrylo1[25:0]};
            end
            if (op == op_tlbp) begin
                // P bit flags a failed probe
                probe_index <= hit ? {{(32-TLB_IDX_W){1'b0}}, hit_index} : 32'h8000_0000;
            end
        end
    end

    // an indexed write must name an existing entry
    assert property (@(posedge clk) disable iff (!rst_n)
        (op == op_tlbwi) |-> (index < TLB_ENTRIES));

endmodule

`default_nettype wire

// File: source/tlb_translate.sv
`timescale 1ns/1ps
`default_nettype none

module tlb_translate import mmu_pkg::*; (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          req,
    input  wire logic                          wr,
    input  wire logic [31:0]                   vaddr,
    input  wire logic [7:0]                    asid,
    input  wire logic                          stall,
    input  wire logic                          probe,
    input  wire logic [18:0]                   probe_vpn2,
    input  wire logic [TLB_ENTRIES*19-1:0]     ent_vpn2,
    input  wire logic [TLB_ENTRIES*8-1:0]      ent_asid,
    input  wire logic [TLB_ENTRIES-1:0]        ent_g,
    input  wire logic [TLB_ENTRIES*25-1:0]     ent_lo0,
    input  wire logic [TLB_ENTRIES*25-1:0]     ent_lo1,
    output logic                               done,
    output logic      [31:0]                   paddr,
    output logic                               cached,
    output tlb_exc_e                           exc,
    output logic                               hit,
    output logic      [TLB_IDX_W-1:0]          hit_index
);

    logic [3:0]  seg;
    logic        mapped;
    logic        kseg0;
    logic [18:0] key;
    logic [24:0] sel_lo;
    logic [19:0] pfn;
    logic [2:0]  c;
    logic        d;
    logic        v;
    logic [31:0] paddr_d;
    logic        cached_d;
    tlb_exc_e    exc_d;

    assign seg    = vaddr[31:28];
    assign kseg0  = (seg[3:1] == 3'b100);
    // kuseg below 0x8, kseg2/kseg3 from 0xC
    assign mapped = !seg[3] || (seg[3:2] == 2'b11);
    assign key    = probe ? probe_vpn2 : vaddr[31:13];

    // walk down so the lowest matching entry wins
    always_comb begin
        hit       = 1'b0;
        hit_index = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (ent_vpn2[i*19 +: 19] == key && (ent_g[i] || ent_asid[i*8 +: 8] == asid)) begin
                hit       = 1'b1;
                hit_index = TLB_IDX_W'(i);
            end
        end
    end

    assign sel_lo = vaddr[12] ? ent_lo1[hit_index*25 +: 25] : ent_lo0[hit_index*25 +: 25];
    assign {pfn, c, d, v} = sel_lo;

    always_comb begin
        paddr_d  = {pfn, vaddr[11:0]};
        cached_d = (c == CACHE_CACHED);
        exc_d    = exc_none;
        if (!mapped) begin
            paddr_d  = {seg - (kseg0 ? 4'h8 : 4'hA), vaddr[27:0]};
            cached_d = kseg0;
        end else if (!hit) begin
            exc_d = wr ? exc_refill_store : exc_refill_load;
        end else if (!v) begin
            exc_d = wr ? exc_invalid_store : exc_invalid_load;
        end else if (wr && !d) begin
            exc_d = exc_modified;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done   <= 1'b0;
            paddr  <= '0;
            cached <= 1'b0;
            exc    <= exc_none;
        end else begin
            done <= req && !stall;
            if (req && !stall) begin
                paddr  <= paddr_d;
                cached <= cached_d;
                exc    <= exc_d;
            end
        end
    end

    // a stalled request stays on the port until it completes
    assert property (@(posedge clk) disable iff (!rst_n)
        req && stall |=> req && $stable(vaddr) && $stable(wr));

endmodule

`default_nettype wire

// File: source/tlb_entry_array.sv
`timescale 1ns/1ps
`default_nettype none

module tlb_entry_array import mmu_pkg::*; (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          wr_en,
    input  wire logic [TLB_IDX_W-1:0]          wr_index,
    input  wire logic [31:0]                   wr_entryhi,
    input  wire logic [31:0]                   wr_entrylo0,
    input  wire logic [31:0]                   wr_entrylo1,
    input  wire logic [TLB_IDX_W-1:0]          rd_index,
    output logic      [31:0]                   rd_entryhi,
    output logic      [31:0]                   rd_entrylo0,
    output logic      [31:0]                   rd_entrylo1,
    output logic      [TLB_ENTRIES*19-1:0]     ent_vpn2,
    output logic      [TLB_ENTRIES*8-1:0]      ent_asid,
    output logic      [TLB_ENTRIES-1:0]        ent_g,
    output logic      [TLB_ENTRIES*25-1:0]     ent_lo0,
    output logic      [TLB_ENTRIES*25-1:0]     ent_lo1
);

    logic [18:0] vpn2_q [TLB_ENTRIES];
    logic [7:0]  asid_q [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] g_q;
    // {pfn, c, d} per page
    logic [23:0] pg0_q [TLB_ENTRIES];
    logic [23:0] pg1_q [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] v0_q;
    logic [TLB_ENTRIES-1:0] v1_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            v0_q <= '0;
            v1_q <= '0;
        end else if (wr_en) begin
            v0_q[wr_index] <= wr_entrylo0[LO_V_BIT];
            v1_q[wr_index] <= wr_entrylo1[LO_V_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            vpn2_q[wr_index] <= wr_entryhi[31:13];
            asid_q[wr_index] <= wr_entryhi[7:0];
            // global only when both halves say so
            g_q[wr_index]    <= wr_entrylo0[LO_G_BIT] & wr_entrylo1[LO_G_BIT];
            pg0_q[wr_index]  <= {wr_entrylo0[LO_PFN_LSB +: 20], wr_entrylo0[LO_C_LSB +: 3],
                                 wr_entrylo0[LO_D_BIT]};
            pg1_q[wr_index]  <= {wr_entrylo1[LO_PFN_LSB +: 20], wr_entrylo1[LO_C_LSB +: 3],
                                 wr_entrylo1[LO_D_BIT]};
        end
    end

    // indexed read in CP0 register format
    always_comb begin
        rd_entryhi  = {vpn2_q[rd_index], 5'b0, asid_q[rd_index]};
        rd_entrylo0 = {6'b0, pg0_q[rd_index], v0_q[rd_index], g_q[rd_index]};
        rd_entrylo1 = {6'b0, pg1_q[rd_index], v1_q[rd_index], g_q[rd_index]};
    end

    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            ent_vpn2[i*19 +: 19] = vpn2_q[i];
            ent_asid[i*8 +: 8]   = asid_q[i];
            ent_lo0[i*25 +: 25]  = {pg0_q[i], v0_q[i]};
            ent_lo1[i*25 +: 25]  = {pg1_q[i], v1_q[i]};
        end
        ent_g = g_q;
    end

endmodule

`default_nettype wire

// File: source/mmu_pkg.sv
`default_nettype none

package mmu_pkg;

    localparam int TLB_ENTRIES = 16;
    localparam int TLB_IDX_W   = 4;

    // C field encoding for cacheable, noncoherent
    localparam logic [2:0] CACHE_CACHED = 3'd3;

    // EntryLo layout: PFN[25:6] C[5:3] D[2] V[1] G[0]
    localparam int LO_PFN_LSB = 6;
    localparam int LO_C_LSB   = 3;
    localparam int LO_D_BIT   = 2;
    localparam int LO_V_BIT   = 1;
    localparam int LO_G_BIT   = 0;

    typedef enum logic [2:0] {
        exc_none          = 3'd0,
        exc_refill_load   = 3'd1,
        exc_refill_store  = 3'd2,
        exc_invalid_load  = 3'd3,
        exc_invalid_store = 3'd4,
        exc_modified      = 3'd5
    } tlb_exc_e;

    typedef enum logic [2:0] {
        op_none  = 3'd0,
        op_tlbr  = 3'd1,
        op_tlbwi = 3'd2,
        op_tlbwr = 3'd3,
        op_tlbp  = 3'd4
    } tlb_op_e;

endpackage

`default_nettype wire
